//--- logic/chipRamPkg.sv
package chipRamPkg;

    ////////////////////
    // Widths
    ////////////////////

    // CPU word address, bus A20 down to A1
    typedef logic [19:0] cpuAddr_t;

    // Multiplexed SDRAM address pins
    typedef logic [10:0] sdramAddr_t;

    // Command in pin order csN, rasN, casN, weN
    typedef logic [3:0] sdramCmd_t;

    // Refresh interval counter
    typedef logic [7:0] refreshCount_t;

    // Step counter inside a sequencer state
    typedef logic [3:0] seqStep_t;

    ////////////////////
    // SDRAM commands
    ////////////////////

    // All active low
    localparam sdramCmd_t cmdNop          = 4'b1111;
    localparam sdramCmd_t cmdPrecharge    = 4'b0010;
    localparam sdramCmd_t cmdActivate     = 4'b0011;
    localparam sdramCmd_t cmdRead         = 4'b0101;
    localparam sdramCmd_t cmdWrite        = 4'b0100;
    localparam sdramCmd_t cmdAutoRefresh  = 4'b0001;
    localparam sdramCmd_t cmdModeRegister = 4'b0000;

    // CAS latency 2, sequential burst of 4
    localparam sdramAddr_t modeWord = 11'b000_0010_0010;

    // A10 high selects all banks on precharge
    localparam sdramAddr_t prechargeAllWord = 11'b100_0000_0000;

    // About 7.8 us at the C1 rate
    localparam refreshCount_t refreshInterval = 8'd27;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        cpuAddr_t addr;
        logic     write;
    } cpuReq_t;

    // Which word the output stage places on ma
    typedef enum logic [2:0] {
        selNone,
        selRow,
        selCol,
        selMode,
        selPrechargeAll
    } addrSel_t;

    // One command slot from the sequencer
    typedef struct packed {
        sdramCmd_t cmd;
        addrSel_t  addrSel;
        cpuAddr_t  addr;
        logic      ack;
    } seqOut_t;

    // SDRAM pin bundle
    typedef struct packed {
        logic       csN;
        logic       rasN;
        logic       casN;
        logic       weN;
        sdramAddr_t ma;
    } sdramBus_t;

    typedef enum logic [1:0] {
        stInit,
        stIdle,
        stRefresh,
        stAccess
    } seqState_t;

endpackage

//--- logic/cpuRequestStage.sv
`timescale 1ns/1ps

module cpuRequestStage (
    input  logic                C1,
    input  logic                REFRESH_RST,
    input  logic                reqValid,
    output logic                reqReady,
    input  chipRamPkg::cpuReq_t req,
    input  logic                dmaBusy,
    input  logic                take,
    output logic                heldValid,
    output chipRamPkg::cpuReq_t heldReq,
    output logic                dmaClear
);
    import chipRamPkg::*;

    // Two samples of the DMA line, index 1 is the older one
    logic [1:0] dmaSync;
    logic       accept;

    ////////////////////
    // Holding register
    ////////////////////

    // Room for one request at a time
    assign reqReady = !heldValid;
    assign accept   = reqValid && reqReady;

    // Valid flag
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            heldValid <= 1'b0;
        end else if (accept) begin
            heldValid <= 1'b1;
        end else if (take) begin
            // Sequencer has copied the request
            heldValid <= 1'b0;
        end
    end

    // Request payload, loaded only on a transfer
    always_ff @(posedge C1) begin
        if (accept) begin
            heldReq <= req;
        end
    end

    ////////////////////
    // DMA synchronizer
    ////////////////////

    // Reset to idle so accesses may start once configured
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            dmaSync <= 2'b00;
        end else begin
            dmaSync <= {dmaSync[0], dmaBusy};
        end
    end

    // Clear only when both samples agree the bus is free
    assign dmaClear = (dmaSync == 2'b00);

endmodule

//--- logic/refreshTimer.sv
`timescale 1ns/1ps

module refreshTimer (
    input  logic C1,
    input  logic REFRESH_RST,
    input  logic refreshDone,
    output logic refreshDue
);
    import chipRamPkg::*;

    // Cycles since the last auto-refresh
    refreshCount_t count;

    ////////////////////
    // Interval counter
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            count <= '0;
        end else if (refreshDone) begin
            // Restart on every issued auto-refresh
            count <= '0;
        end else if (count != '1) begin
            // Saturate so a long wait never wraps
            count <= count + 1'b1;
        end
    end

    // Due flag
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            refreshDue <= 1'b0;
        end else begin
            // Stays up until the counter restarts
            refreshDue <= (count >= refreshInterval);
        end
    end

endmodule

//--- logic/sdramSequencer.sv
`timescale 1ns/1ps

module sdramSequencer (
    input  logic                C1,
    input  logic                REFRESH_RST,
    input  logic                heldValid,
    input  chipRamPkg::cpuReq_t heldReq,
    input  logic                dmaClear,
    input  logic                refreshDue,
    output logic                take,
    output logic                refreshDone,
    output chipRamPkg::seqOut_t seq
);
    import chipRamPkg::*;

    seqState_t state;
    seqStep_t  step;

    // Registered command slot
    sdramCmd_t cmdReg;
    addrSel_t  selReg;
    logic      ackReg;

    // Request copied at activate
    cpuAddr_t  accAddr;
    logic      accWrite;

    logic      startAccess;

    ////////////////////
    // Arbitration
    ////////////////////

    // Refresh wins over a waiting CPU request
    // A DMA owner on the bus also blocks the start
    assign startAccess = (state == stIdle) && !refreshDue && heldValid && dmaClear;

    // Access payload, kept through all five slots
    always_ff @(posedge C1) begin
        if (startAccess) begin
            accAddr  <= heldReq.addr;
            accWrite <= heldReq.write;
        end
    end

    ////////////////////
    // Command FSM
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            state       <= stInit;
            step        <= '0;
            cmdReg      <= cmdNop;
            selReg      <= selNone;
            ackReg      <= 1'b0;
            take        <= 1'b0;
            refreshDone <= 1'b0;
        end else begin
            // Every slot is a NOP unless a branch below says otherwise
            cmdReg      <= cmdNop;
            selReg      <= selNone;
            ackReg      <= 1'b0;
            take        <= 1'b0;
            refreshDone <= 1'b0;

            case (state)
                // Power-up configuration, fixed 13 step schedule
                stInit: begin
                    step <= step + 1'b1;
                    case (step)
                        4'd0: begin
                            cmdReg <= cmdPrecharge;
                            selReg <= selPrechargeAll;
                        end
                        4'd2: begin
                            cmdReg <= cmdModeRegister;
                            selReg <= selMode;
                        end
                        4'd5, 4'd9: begin
                            // Two refreshes before normal use
                            cmdReg      <= cmdAutoRefresh;
                            refreshDone <= 1'b1;
                        end
                        4'd12: begin
                            state <= stIdle;
                            step  <= '0;
                        end
                        default: begin
                        end
                    endcase
                end

                // Waiting for work
                stIdle: begin
                    if (refreshDue) begin
                        cmdReg      <= cmdAutoRefresh;
                        refreshDone <= 1'b1;
                        state       <= stRefresh;
                        step        <= 4'd1;
                    end else if (startAccess) begin
                        // Row open, holding register freed in the same slot
                        cmdReg <= cmdActivate;
                        selReg <= selRow;
                        take   <= 1'b1;
                        state  <= stAccess;
                        step   <= 4'd1;
                    end
                end

                // Three NOPs cover the refresh cycle time
                stRefresh: begin
                    if (step == 4'd3) begin
                        state <= stIdle;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end

                // Activate, NOP, read or write, precharge, NOP
                stAccess: begin
                    step <= step + 1'b1;
                    case (step)
                        4'd2: begin
                            // RAS to CAS delay met by the NOP before
                            cmdReg <= accWrite ? cmdWrite : cmdRead;
                            selReg <= selCol;
                        end
                        4'd3: begin
                            // CPU may finish its cycle here
                            cmdReg <= cmdPrecharge;
                            selReg <= selPrechargeAll;
                            ackReg <= 1'b1;
                        end
                        4'd4: begin
                            state <= stIdle;
                            step  <= '0;
                        end
                        default: begin
                        end
                    endcase
                end

                default: begin
                    state <= stIdle;
                    step  <= '0;
                end
            endcase
        end
    end

    // Slot handed to the output stage
    assign seq = '{cmd: cmdReg, addrSel: selReg, addr: accAddr, ack: ackReg};

endmodule

//--- logic/sdramCommandOut.sv
`timescale 1ns/1ps

module sdramCommandOut (
    input  logic                  C1,
    input  logic                  REFRESH_RST,
    input  chipRamPkg::seqOut_t   seq,
    output chipRamPkg::sdramBus_t sdram,
    output logic                  cpuAck
);
    import chipRamPkg::*;

    sdramAddr_t rowAddr;
    sdramAddr_t colAddr;

    ////////////////////
    // Address mux
    ////////////////////

    // addr[k] is bus line A(k+1)
    // Row is 0, A19, A17 down to A9
    assign rowAddr = {1'b0, seq.addr[18], seq.addr[16:8]};

    // Column is 000, A18, A8 down to A2
    assign colAddr = {3'b000, seq.addr[17], seq.addr[7:1]};

    ////////////////////
    // Pin register
    ////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            // NOP on the bus, ma parked at zero
            sdram  <= '{csN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1, ma: '0};
            cpuAck <= 1'b0;
        end else begin
            {sdram.csN, sdram.rasN, sdram.casN, sdram.weN} <= seq.cmd;

            // Same edge as the precharge command
            cpuAck <= seq.ack;

            case (seq.addrSel)
                selRow:          sdram.ma <= rowAddr;
                selCol:          sdram.ma <= colAddr;
                selMode:         sdram.ma <= modeWord;
                selPrechargeAll: sdram.ma <= prechargeAllWord;
                // ma stays put during NOPs
                default:         sdram.ma <= sdram.ma;
            endcase
        end
    end

endmodule

//--- logic/chipRamController.sv
`timescale 1ns/1ps

module chipRamController (
    input  logic                  C1,
    input  logic                  REFRESH_RST,
    input  logic                  reqValid,
    output logic                  reqReady,
    input  chipRamPkg::cpuReq_t   req,
    input  logic                  dmaBusy,
    output logic                  cpuAck,
    output chipRamPkg::sdramBus_t sdram
);
    import chipRamPkg::*;

    // Request stage to sequencer
    logic    heldValid;
    cpuReq_t heldReq;
    logic    take;
    logic    dmaClear;

    // Refresh scheduling
    logic    refreshDue;
    logic    refreshDone;

    // Sequencer to pin stage
    seqOut_t seq;

    ////////////////////
    // Stages
    ////////////////////

    cpuRequestStage requestStage (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .dmaBusy     (dmaBusy),
        .take        (take),
        .heldValid   (heldValid),
        .heldReq     (heldReq),
        .dmaClear    (dmaClear)
    );

    refreshTimer refreshTiming (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .refreshDone (refreshDone),
        .refreshDue  (refreshDue)
    );

    sdramSequencer sequencer (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .heldValid   (heldValid),
        .heldReq     (heldReq),
        .dmaClear    (dmaClear),
        .refreshDue  (refreshDue),
        .take        (take),
        .refreshDone (refreshDone),
        .seq         (seq)
    );

    sdramCommandOut commandOut (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .seq         (seq),
        .sdram       (sdram),
        .cpuAck      (cpuAck)
    );

endmodule

//--- verif/chipRamTb.sv
`timescale 1ns/1ps

module chipRamTb;
    import chipRamPkg::*;

    // SDRAM truth table, csN rasN casN weN
    localparam logic [3:0] opNop   = 4'b1111;
    localparam logic [3:0] opPre   = 4'b0010;
    localparam logic [3:0] opAct   = 4'b0011;
    localparam logic [3:0] opRead  = 4'b0101;
    localparam logic [3:0] opWrite = 4'b0100;
    localparam logic [3:0] opRef   = 4'b0001;
    localparam logic [3:0] opMode  = 4'b0000;
    // Minimum cycles between auto-refreshes
    localparam int minRefreshGap = 27;

    logic      C1 = 1'b0;
    logic      REFRESH_RST;
    logic      reqValid;
    logic      reqReady;
    cpuReq_t   req;
    logic      dmaBusy;
    logic      cpuAck;
    sdramBus_t sdram;

    // Golden entries
    logic [19:0] gAddr[$];
    logic        gWrite[$];
    int          gHold[$];
    logic [10:0] gRow[$];
    logic [10:0] gCol[$];
    logic [3:0]  gCmd[$];

    // Expected accesses in acceptance order
    logic [10:0] expRow[$];
    logic [10:0] expCol[$];
    logic [3:0]  expCmd[$];
    longint      accTime[$];
    bit          latChk[$];

    int          seed = 32'h8b73d6d8;
    int          mismatches = 0;
    int          failures = 0;
    int          ackCount = 0;
    int          acceptCount = 0;
    int          activateCount = 0;
    int          refreshSeen = 0;
    int          initSeen = 0;
    int          phase = 0;
    longint      lastRefresh = 0;
    logic [3:0]  prevOp = 4'b1111;
    logic [10:0] prevMa = 11'd0;
    logic [3:0]  initCmd[4];
    logic [10:0] initMa[4];
    bit          dmaWindow = 1'b0;
    bit          loaded = 1'b0;

    always #2 C1 = ~C1;

    chipRamController DUT (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .req         (req),
        .dmaBusy     (dmaBusy),
        .cpuAck      (cpuAck),
        .sdram       (sdram)
    );

    task automatic reportMismatch(string msg);
        mismatches++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic reportFailure(string msg);
        failures++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    ////////////////////
    // Pin monitor
    ////////////////////

    // Pins are sampled mid cycle, away from the driving edge
    always @(negedge C1) begin : pinMonitor
        logic [3:0] op;
        longint     lat;
        op = {sdram.csN, sdram.rasN, sdram.casN, sdram.weN};
        if (!REFRESH_RST) begin
            if (op != opNop && initSeen < 4) begin
                initCmd[initSeen] = op;
                initMa[initSeen]  = sdram.ma;
                initSeen++;
            end
            if (cpuAck) begin
                assert (op == opPre && phase == 2)
                else reportFailure("cpuAck outside the precharge of an access");
            end
            case (op)
                opNop: begin
                    // Address pins hold still between commands
                    assert (sdram.ma == prevMa)
                    else reportMismatch($sformatf("ma moved to %h during a NOP", sdram.ma));
                end
                opAct: begin
                    activateCount++;
                    assert (phase == 0) else reportFailure("activate inside an open access");
                    assert (!dmaWindow) else reportFailure("activate while DMA holds the bus");
                    if (expRow.size() == 0) begin
                        reportFailure("activate without an accepted request");
                    end else begin
                        assert (sdram.ma == expRow[0])
                        else reportMismatch($sformatf("row %h, expected %h", sdram.ma, expRow[0]));
                    end
                    phase = 1;
                end
                opRead, opWrite: begin
                    if (phase == 1 && expCmd.size() > 0) begin
                        assert (op == expCmd[0])
                        else reportMismatch($sformatf("command %b, expected %b", op, expCmd[0]));
                        assert (sdram.ma == expCol[0])
                        else reportMismatch($sformatf("column %h, expected %h", sdram.ma, expCol[0]));
                    end else begin
                        reportFailure("read or write without a preceding activate");
                    end
                    phase = 2;
                end
                opPre: begin
                    // Every precharge closes all banks
                    assert (sdram.ma == 11'h400)
                    else reportMismatch($sformatf("precharge ma %h, expected 400", sdram.ma));
                    // Precharge with phase 0 belongs to the power-up schedule
                    if (phase != 0) begin
                        assert (phase == 2 && (prevOp == opRead || prevOp == opWrite))
                        else reportFailure("precharge does not directly follow the column command");
                        assert (cpuAck) else reportFailure("no cpuAck in the precharge cycle");
                        ackCount++;
                        if (expRow.size() > 0) begin
                            // Cycles counted from the accepting edge
                            lat = ($time - accTime[0] + 2) / 4;
                            if (latChk[0] && lastRefresh + 16 < accTime[0]) begin
                                assert (lat == 6)
                                else reportMismatch($sformatf("ack latency %0d, expected 6", lat));
                            end
                            void'(expRow.pop_front());
                            void'(expCol.pop_front());
                            void'(expCmd.pop_front());
                            void'(accTime.pop_front());
                            void'(latChk.pop_front());
                        end
                        phase = 0;
                    end
                end
                opRef: begin
                    assert (phase == 0) else reportFailure("auto-refresh overlaps a CPU access");
                    // The two power-up refreshes are closer by design
                    if (refreshSeen >= 2) begin
                        assert (($time - lastRefresh) / 4 >= minRefreshGap)
                        else reportFailure("two auto-refreshes closer than the refresh interval");
                    end
                    refreshSeen++;
                    lastRefresh = $time;
                end
                default: begin
                end
            endcase
            prevOp = op;
            prevMa = sdram.ma;
        end
    end

    ////////////////////
    // Request driver
    ////////////////////

    // Called on a rising edge, returns one edge after the transfer
    task automatic offerRequest(int idx, bit latencyCheck);
        reqValid <= 1'b1;
        req      <= '{addr: gAddr[idx], write: gWrite[idx]};
        do @(posedge C1); while (!reqReady);
        // Every earlier request must already have its activate
        assert (acceptCount == activateCount)
        else reportFailure("request accepted while another one is still held");
        reqValid <= 1'b0;
        acceptCount++;
        expRow.push_back(gRow[idx]);
        expCol.push_back(gCol[idx]);
        expCmd.push_back(gCmd[idx]);
        accTime.push_back($time);
        latChk.push_back(latencyCheck);
        @(posedge C1);
        assert (!reqReady) else reportFailure("reqReady high while the holding register is full");
    endtask

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = gAddr.size() * 60 + 200;
        repeat (limit) @(posedge C1);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : mainSequence
        int          fd;
        int          code;
        int          hold;
        int          gap;
        int          target;
        int          wr;
        string       line;
        logic [19:0] a;
        logic [10:0] r;
        logic [10:0] c;
        logic [3:0]  cmd;
        REFRESH_RST = 1'b1;
        reqValid    = 1'b0;
        req         = '0;
        dmaBusy     = 1'b0;

        fd = $fopen("verif/chipRamGolden.txt", "r");
        if (fd == 0) begin
            reportFailure("cannot open the golden file");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // Skip column notes and blank lines
                if (code > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%h %d %d %h %h %h", a, wr, hold, r, c, cmd);
                    if (code == 6) begin
                        gAddr.push_back(a);
                        gWrite.push_back(wr[0]);
                        gHold.push_back(hold);
                        gRow.push_back(r);
                        gCol.push_back(c);
                        gCmd.push_back(cmd);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (16) @(posedge C1);
        // Reset state of the pins
        assert ({sdram.csN, sdram.rasN, sdram.casN, sdram.weN} == opNop && sdram.ma == 11'd0)
        else reportMismatch("pins not at NOP with ma zero during reset");
        assert (!cpuAck && reqReady) else reportMismatch("cpuAck or reqReady wrong in reset");
        REFRESH_RST <= 1'b0;

        // Power-up configuration order
        while (initSeen < 4) @(posedge C1);
        assert (initCmd[0] == opPre && initMa[0] == 11'h400)
        else reportMismatch("first command is not precharge-all");
        assert (initCmd[1] == opMode && initMa[1] == 11'h022)
        else reportMismatch("second command is not the mode register write");
        assert (initCmd[2] == opRef && initCmd[3] == opRef)
        else reportMismatch("power-up refreshes missing");
        assert (reqReady && ackCount == 0) else reportMismatch("handshake busy after power-up");

        // One request at a time, with DMA holds and random gaps
        foreach (gAddr[i]) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge C1);
            target = ackCount + 1;
            if (gHold[i] > 0) begin
                dmaBusy <= 1'b1;
                // Let the synchronizer see the busy line
                repeat (3) @(posedge C1);
                dmaWindow = 1'b1;
                offerRequest(i, 1'b0);
                repeat (gHold[i]) @(posedge C1);
                dmaWindow = 1'b0;
                dmaBusy <= 1'b0;
            end else begin
                offerRequest(i, 1'b1);
            end
            while (ackCount < target) @(posedge C1);
        end

        // Back-to-back stream with back-pressure
        foreach (gAddr[i]) begin
            offerRequest(i, 1'b0);
        end
        while (ackCount < acceptCount) @(posedge C1);
        repeat (4) @(posedge C1);
        assert (expRow.size() == 0 && ackCount == 2 * gAddr.size())
        else reportFailure("accepted requests and acknowledges do not match");

        $display("Mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verif/chipRamGolden.txt
# addr(hex) write dmaHold(cycles) row(hex) col(hex) cmd(hex)
# cmd 5 is a read and 4 is a write, row and column as driven on ma
00000 0 0 000 000 5
FFFFF 1 0 3FF 0FF 4
40000 0 0 200 000 5
20000 1 4 000 080 4
10000 0 0 100 000 5
00100 1 0 001 000 4
00002 0 7 000 001 5
000FE 1 0 000 07F 4
00001 0 0 000 000 5
80000 1 0 000 000 4
12345 0 3 123 022 5
ABCDE 1 0 0BC 0EF 4
5A5A5 0 0 3A5 052 5
3C3C3 1 5 1C3 0E1 4
7FFFF 0 0 3FF 0FF 5
0FF00 1 0 0FF 000 4
000FF 0 0 000 07F 5
6789A 1 9 278 0CD 4
24680 0 0 046 0C0 5
13579 1 0 135 03C 4
55555 0 2 355 02A 5
AAAAA 1 0 0AA 0D5 4

//--- filelist.f
logic/chipRamPkg.sv
logic/cpuRequestStage.sv
logic/refreshTimer.sv
logic/sdramSequencer.sv
logic/sdramCommandOut.sv
logic/chipRamController.sv
verif/chipRamTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the chip-RAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module chipRamTb -f filelist.f \
    --Mdir obj_dir -o chipRamSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/chipRamSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
else
    exit 1
fi
